// File: uart_char_pkg.sv
package uart_char_pkg;

    // --------------------
    // character codes
    // --------------------

    typedef logic [7:0] byte_t;

    localparam byte_t CHAR_ZERO  = 8'h30;
    localparam byte_t CHAR_ONE   = 8'h31;
    localparam byte_t CHAR_EQUAL = 8'h3D;
    localparam byte_t CHAR_SHARP = 8'h23;

    // --------------------
    // receive side
    // --------------------

    // one accepted character
    typedef struct packed {
        logic  take;
        logic  last;
        byte_t chr;
    } rx_event_t;

    // --------------------
    // transmit side
    // --------------------

    typedef enum logic [1:0] {
        TX_ECHO,
        TX_EQUAL,
        TX_BIT,
        TX_SHARP
    } tx_kind_t;

    typedef struct packed {
        logic     send;
        tx_kind_t kind;
    } tx_req_t;

endpackage

// File: cut_vector_pkg.sv
package cut_vector_pkg;

    // --------------------
    // word layout
    // --------------------

    localparam int WORD_BITS = 32;

    typedef logic [WORD_BITS-1:0] word_t;

    // first character of a frame lands in cut_clk
    typedef struct packed {
        logic  cut_clk;
        logic  cut_nrst;
        word_t v0;
        word_t v1;
        word_t k0;
        word_t k1;
        word_t k2;
        word_t k3;
    } cut_stimulus_t;

    typedef struct packed {
        word_t v0;
        word_t v1;
    } cut_response_t;

    // --------------------
    // frame sizes
    // --------------------

    localparam int STIM_BITS = 2 + 6 * WORD_BITS;
    localparam int RESP_BITS = 2 * WORD_BITS;

    typedef logic [7:0] stim_count_t;
    typedef logic [6:0] resp_count_t;

endpackage

// File: frame_collector.sv
`timescale 1ns/10ps

module frame_collector
    import uart_char_pkg::*, cut_vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  byte_t         rx_data,
    input  logic          rx_ready,
    input  logic          listening,
    output rx_event_t     rx_event,
    output cut_stimulus_t stimulus
);

    logic                 rx_take;
    logic                 rx_bit;
    logic                 frame_last;
    stim_count_t          stim_cnt;
    logic [STIM_BITS-1:0] shift_q;
    logic [STIM_BITS-1:0] shift_d;

    // --------------------
    // accept and convert
    // --------------------

    assign rx_take    = rx_ready && listening;
    assign frame_last = rx_take && (stim_cnt == stim_count_t'(STIM_BITS - 1));

    // '0' gives 0, anything else 1
    assign rx_bit = (rx_data == CHAR_ZERO) ? 1'b0 : 1'b1;

    assign rx_event.take = rx_take;
    assign rx_event.last = frame_last;
    assign rx_event.chr  = rx_data;

    // newest bit enters at the bottom
    assign shift_d = {shift_q[STIM_BITS-2:0], rx_bit};

    // --------------------
    // shift and count
    // --------------------

    always_ff @(posedge clk)
    begin
        if (rx_take)
        begin
            shift_q <= shift_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stim_cnt <= '0;
            stimulus <= '0;
        end
        else if (frame_last)
        begin
            stim_cnt <= '0;
            stimulus <= cut_stimulus_t'(shift_d);
        end
        else if (rx_take)
        begin
            stim_cnt <= stim_cnt + 1'b1;
        end
    end

    // frame counter wraps at the last character
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        stim_cnt < stim_count_t'(STIM_BITS));

endmodule

// File: loopback_sequencer.sv
`timescale 1ns/10ps

module loopback_sequencer
    import uart_char_pkg::*, cut_vector_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tx_ready,
    input  rx_event_t rx_event,
    output logic      listening,
    output tx_req_t   tx_req
);

    typedef enum logic [2:0] {
        LISTEN,
        ECHO_GAP,
        DRAIN_ECHO,
        SEND_EQUAL,
        WAIT_BUSY,
        SEND_BIT,
        TAIL_GAP,
        SEND_SHARP
    } state_t;

    state_t      state_q;
    state_t      state_d;
    resp_count_t bit_cnt;
    logic        last_bit;

    assign listening = (state_q == LISTEN);
    assign last_bit  = (bit_cnt == resp_count_t'(RESP_BITS - 1));

    // --------------------
    // next state
    // --------------------

    always_comb
    begin
        state_d     = state_q;
        tx_req.send = 1'b0;
        tx_req.kind = TX_ECHO;
        unique case (state_q)
            LISTEN:
            begin
                // echo goes out without waiting for tx_ready
                if (rx_event.take)
                begin
                    tx_req.send = 1'b1;
                    tx_req.kind = TX_ECHO;
                    state_d     = rx_event.last ? DRAIN_ECHO : ECHO_GAP;
                end
            end
            ECHO_GAP:
            begin
                state_d = LISTEN;
            end
            DRAIN_ECHO:
            begin
                if (!tx_ready)
                begin
                    state_d = SEND_EQUAL;
                end
            end
            SEND_EQUAL:
            begin
                if (tx_ready)
                begin
                    tx_req.send = 1'b1;
                    tx_req.kind = TX_EQUAL;
                    state_d     = WAIT_BUSY;
                end
            end
            WAIT_BUSY:
            begin
                if (!tx_ready)
                begin
                    state_d = SEND_BIT;
                end
            end
            SEND_BIT:
            begin
                if (tx_ready)
                begin
                    tx_req.send = 1'b1;
                    tx_req.kind = TX_BIT;
                    state_d     = last_bit ? TAIL_GAP : WAIT_BUSY;
                end
            end
            TAIL_GAP:
            begin
                state_d = SEND_SHARP;
            end
            SEND_SHARP:
            begin
                if (tx_ready)
                begin
                    tx_req.send = 1'b1;
                    tx_req.kind = TX_SHARP;
                    state_d     = LISTEN;
                end
            end
        endcase
    end

    // --------------------
    // state and bit count
    // --------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= LISTEN;
            bit_cnt <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (tx_req.send && tx_req.kind == TX_BIT)
            begin
                bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
            end
        end
    end

    // reply traffic only goes to an idle transmitter
    a_reply_paced: assert property (@(posedge clk) disable iff (rst)
        (tx_req.send && tx_req.kind != TX_ECHO) |-> tx_ready);

    // collector must not accept while a reply is running
    a_take_listen: assert property (@(posedge clk) disable iff (rst)
        rx_event.take |-> state_q == LISTEN);

endmodule

// File: reply_serializer.sv
`timescale 1ns/10ps

module reply_serializer
    import uart_char_pkg::*, cut_vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  tx_req_t       tx_req,
    input  rx_event_t     rx_event,
    input  cut_response_t response,
    output logic          tx_start,
    output byte_t         tx_data
);

    cut_response_t        snap_q;
    logic [RESP_BITS-1:0] snap_bits;
    byte_t                bit_chr;

    assign snap_bits = snap_q;

    // v0 msb leaves first
    assign bit_chr = snap_bits[RESP_BITS-1] ? CHAR_ONE : CHAR_ZERO;

    // --------------------
    // response snapshot
    // --------------------

    always_ff @(posedge clk)
    begin
        if (tx_req.send && tx_req.kind == TX_EQUAL)
        begin
            snap_q <= response;
        end
        else if (tx_req.send && tx_req.kind == TX_BIT)
        begin
            snap_q <= cut_response_t'({snap_bits[RESP_BITS-2:0], 1'b0});
        end
    end

    // --------------------
    // transmit byte
    // --------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_start <= 1'b0;
            tx_data  <= '0;
        end
        else
        begin
            tx_start <= tx_req.send;
            if (tx_req.send)
            begin
                unique case (tx_req.kind)
                    TX_ECHO:  tx_data <= rx_event.chr;
                    TX_EQUAL: tx_data <= CHAR_EQUAL;
                    TX_BIT:   tx_data <= bit_chr;
                    TX_SHARP: tx_data <= CHAR_SHARP;
                endcase
            end
        end
    end

    // gap states keep start pulses apart
    a_start_single: assert property (@(posedge clk) disable iff (rst)
        tx_start |=> !tx_start);

endmodule

// File: loopback_device.sv
`timescale 1ns/10ps

module loopback_device
    import uart_char_pkg::*, cut_vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // uart side
    input  byte_t         rx_data,
    input  logic          rx_ready,
    input  logic          tx_ready,
    output logic          tx_start,
    output byte_t         tx_data,

    // cut side
    output cut_stimulus_t stimulus,
    input  cut_response_t response
);

    logic      listening;
    rx_event_t rx_event;
    tx_req_t   tx_req;

    frame_collector u_collector (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .listening (listening),
        .rx_event  (rx_event),
        .stimulus  (stimulus)
    );

    loopback_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .tx_ready  (tx_ready),
        .rx_event  (rx_event),
        .listening (listening),
        .tx_req    (tx_req)
    );

    reply_serializer u_serializer (
        .clk      (clk),
        .rst      (rst),
        .tx_req   (tx_req),
        .rx_event (rx_event),
        .response (response),
        .tx_start (tx_start),
        .tx_data  (tx_data)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/10ps

module tb_clock
(
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD);
            clk = ~clk;
        end
    end

    // reset held over two rising edges
    initial
    begin
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: loopback_tb.sv
`timescale 1ns/10ps

module loopback_tb
    import uart_char_pkg::*, cut_vector_pkg::*;
;

    localparam int FRAMES        = 4;
    localparam int FRAME_CYCLES  = 2500;
    localparam int CLK_PERIOD_NS = 20;
    localparam int TIMEOUT_NS    = FRAMES * FRAME_CYCLES * CLK_PERIOD_NS * 2;

    logic          clk;
    logic          rst;
    byte_t         rx_data;
    logic          rx_ready;
    logic          tx_ready;
    logic          tx_start;
    byte_t         tx_data;
    cut_stimulus_t stimulus;
    cut_response_t response;

    // expected transmit bytes with bit 8 marking reply traffic
    logic [8:0]    exp_q[$];
    int            err_count = 0;
    int            frames_done = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    loopback_device dut (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .tx_ready (tx_ready),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .stimulus (stimulus),
        .response (response)
    );

    // --------------------
    // random bits
    // --------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    // --------------------
    // reference model
    // --------------------

    // first character lands in cut_clk at the top of the struct
    function automatic cut_stimulus_t expected_stimulus(input byte_t chars [STIM_BITS]);
        logic [STIM_BITS-1:0] bits;
        for (int i = 0; i < STIM_BITS; i++)
        begin
            bits[STIM_BITS-1-i] = (chars[i] != 8'h30);
        end
        return cut_stimulus_t'(bits);
    endfunction

    // one '0' or '1' per bit with v0 msb first
    function automatic logic [8*RESP_BITS-1:0] expected_reply(input cut_response_t r);
        logic [RESP_BITS-1:0]   bits;
        logic [8*RESP_BITS-1:0] chars;
        bits = r;
        for (int i = 0; i < RESP_BITS; i++)
        begin
            chars[8*(RESP_BITS-1-i) +: 8] = bits[RESP_BITS-1-i] ? 8'h31 : 8'h30;
        end
        return chars;
    endfunction

    task automatic send_char(input byte_t c, inout logic [31:0] st);
        logic [31:0] gap;
        rx_data  <= c;
        rx_ready <= 1'b1;
        @(posedge clk);
        rx_ready <= 1'b0;
        take_bits(st, 2, gap);
        repeat (2 + int'(gap[1:0])) @(posedge clk);
    endtask

    // --------------------
    // uart transmitter model
    // --------------------

    initial
    begin : tx_model
        logic [31:0] st;
        logic [31:0] v;
        int          busy;
        st   = 32'h2263;
        busy = 0;
        tx_ready <= 1'b1;
        forever
        begin
            @(posedge clk);
            if (tx_start)
            begin
                take_bits(st, 3, v);
                busy = 2 + int'(v[2:0]);
                tx_ready <= 1'b0;
            end
            else if (busy > 0)
            begin
                busy--;
                if (busy == 0)
                begin
                    tx_ready <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // comparison
    // --------------------

    initial
    begin : compare
        logic [8:0]             exp;
        logic                   ready_d;
        logic [31:0]            st;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [8*RESP_BITS-1:0] reply;
        ready_d = 1'b1;
        st      = 32'h2263;
        take_bits(st, 32, a);
        take_bits(st, 32, b);
        response <= cut_response_t'({a, b});
        forever
        begin
            @(posedge clk);
            if (!rst && tx_start)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    $display("tx_start at %0t with no character pending", $time);
                    err_count++;
                end
                if (exp_q.size() > 0)
                begin
                    exp = exp_q.pop_front();
                    assert (tx_data == exp[7:0])
                    else
                    begin
                        $display("FAIL t=%0t tx_data expected %h got %h",
                                 $time, exp[7:0], tx_data);
                        err_count++;
                    end
                    if (exp[8])
                    begin
                        assert (ready_d)
                        else
                        begin
                            $display("reply character at %0t sent to a busy transmitter", $time);
                            err_count++;
                        end
                        if (exp[7:0] == CHAR_EQUAL)
                        begin
                            reply = expected_reply(response);
                            for (int i = 0; i < RESP_BITS; i++)
                            begin
                                exp_q.push_back({1'b1, reply[8*(RESP_BITS-1-i) +: 8]});
                            end
                            exp_q.push_back({1'b1, CHAR_SHARP});
                            // new value right after '=' must not reach the reply
                            take_bits(st, 32, a);
                            take_bits(st, 32, b);
                            response <= cut_response_t'({a, b});
                        end
                        else if (exp[7:0] == CHAR_SHARP)
                        begin
                            frames_done++;
                        end
                    end
                end
            end
            ready_d = tx_ready;
        end
    end

    // --------------------
    // stimulus
    // --------------------

    initial
    begin : stim
        byte_t         chars [STIM_BITS];
        cut_stimulus_t prev_stim;
        cut_stimulus_t want;
        logic [31:0]   seed;
        logic [31:0]   v;
        int            err_start;
        int            failed;
        rx_data  <= '0;
        rx_ready <= 1'b0;
        seed      = 32'h2263;
        prev_stim = '0;
        failed    = 0;
        @(negedge rst);
        @(posedge clk);
        assert (tx_start == 1'b0 && stimulus == '0)
        else
        begin
            $display("FAIL t=%0t tx_start/stimulus expected 0 got %b/%h",
                     $time, tx_start, stimulus);
            err_count++;
        end
        $display("test reset: %s", (err_count == 0) ? "ok" : "errors");
        failed += (err_count == 0) ? 0 : 1;

        for (int f = 0; f < FRAMES; f++)
        begin
            err_start = err_count;
            for (int i = 0; i < STIM_BITS; i++)
            begin
                take_bits(seed, 2, v);
                case (v[1:0])
                    2'd0:    chars[i] = 8'h30;
                    2'd1:    chars[i] = 8'h31;
                    2'd2:    chars[i] = 8'h30;
                    default:
                    begin
                        take_bits(seed, 8, v);
                        chars[i] = v[7:0];
                    end
                endcase
            end
            want = expected_stimulus(chars);
            for (int i = 0; i < STIM_BITS; i++)
            begin
                // previous frame holds until the last character
                assert (stimulus == prev_stim)
                else
                begin
                    $display("FAIL t=%0t stimulus expected %h got %h",
                             $time, prev_stim, stimulus);
                    err_count++;
                end
                exp_q.push_back({1'b0, chars[i]});
                if (i == STIM_BITS - 1)
                begin
                    exp_q.push_back({1'b1, CHAR_EQUAL});
                end
                send_char(chars[i], seed);
            end
            assert (stimulus == want)
            else
            begin
                $display("FAIL t=%0t stimulus expected %h got %h", $time, want, stimulus);
                err_count++;
            end
            wait (frames_done == f + 1);
            @(posedge clk);
            prev_stim = want;
            $display("test frame %0d: %0d errors", f, err_count - err_start);
            failed += (err_count == err_start) ? 0 : 1;
        end

        // catch any stray transmission
        repeat (20) @(posedge clk);
        $display("tests: %0d run, %0d failed, %0d errors", FRAMES + 1, failed, err_count);
        if (err_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, reply sequence did not complete", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: src.f
uart_char_pkg.sv
cut_vector_pkg.sv
frame_collector.sv
loopback_sequencer.sv
reply_serializer.sv
loopback_device.sv
tb_clock.sv
loopback_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert --timescale 1ns/10ps --top-module loopback_tb \
    -f src.f -o loopback_sim || exit 1
out=$(./obj_dir/loopback_sim)
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
